/* common/video_pkg.sv */
package video_pkg;

  // Beam position, wide enough for 800 columns and 525 lines
  typedef logic [9:0] beam_count_t;

  // One channel of the 4-bit DAC
  typedef logic [3:0] colour_t;

  // Visible frame
  localparam beam_count_t screen_width  = 10'd512;
  localparam beam_count_t screen_height = 10'd256;

  // Full 640x480 at 60 Hz raster, counted in pixel clocks and lines
  localparam beam_count_t h_total = 10'd800;
  localparam beam_count_t v_total = 10'd525;

  // Frame is centred in the 640x480 area.
  // Column 0 of the counter is the start of the front porch
  localparam beam_count_t h_disp_start = 10'd224;
  localparam beam_count_t v_disp_start = 10'd112;

  // Sync pulses, both active low, each a half-open interval
  localparam beam_count_t h_sync_start = 10'd16;
  localparam beam_count_t h_sync_end   = 10'd112;
  localparam beam_count_t v_sync_start = 10'd490;
  localparam beam_count_t v_sync_end   = 10'd492;

  // One RAM word holds 16 pixels
  localparam beam_count_t words_per_line = 10'd32;

  // First word of a line is requested this many pixel clocks early
  localparam beam_count_t fetch_lead = 10'd3;

endpackage

/* common/mem_pkg.sv */
package mem_pkg;

  // Word address into the video RAM
  typedef logic [13:0] vram_addr_t;

  // One RAM word, 16 pixels of the frame buffer
  typedef logic [15:0] vram_data_t;

  // Number of words, covers the full address range
  localparam int vram_depth = 16384;

endpackage

/* vga/vga_scanout.sv */
module vga_scanout (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 clken,
  input  mem_pkg::vram_data_t  ram_rdata,
  output logic                 scan_rden,
  output mem_pkg::vram_addr_t  scan_addr,
  output logic                 h_sync,
  output logic                 v_sync,
  output video_pkg::colour_t   red,
  output video_pkg::colour_t   green,
  output video_pkg::colour_t   blue
);

  video_pkg::beam_count_t h_count;
  video_pkg::beam_count_t v_count;
  video_pkg::beam_count_t y;
  logic                   h_end;
  logic                   v_end;
  logic                   h_disp;
  logic                   v_disp;
  logic                   display;
  logic                   pre_fetch;
  logic [3:0]             px_offset;
  logic [5:0]             word_offset;
  mem_pkg::vram_addr_t    row_base;
  mem_pkg::vram_data_t    pixel_word;
  logic                   cur_bit;
  logic                   pixel;

  assign h_end = h_count == video_pkg::h_total - 10'd1;
  assign v_end = v_count == video_pkg::v_total - 10'd1;

  assign h_disp = h_count >= video_pkg::h_disp_start &&
                  h_count < video_pkg::h_disp_start + video_pkg::screen_width;
  assign v_disp = v_count >= video_pkg::v_disp_start &&
                  v_count < video_pkg::v_disp_start + video_pkg::screen_height;
  assign display = h_disp && v_disp;

  // Last few clocks before the window on a visible row
  assign pre_fetch = v_disp &&
                     h_count >= video_pkg::h_disp_start - video_pkg::fetch_lead &&
                     h_count < video_pkg::h_disp_start;

  // Both syncs are negative polarity for 640x480
  assign h_sync = !(h_count >= video_pkg::h_sync_start && h_count < video_pkg::h_sync_end);
  assign v_sync = !(v_count >= video_pkg::v_sync_start && v_count < video_pkg::v_sync_end);

  // Position inside the window
  assign px_offset = 4'(h_count - video_pkg::h_disp_start);
  assign y         = v_count - video_pkg::v_disp_start;

  assign row_base  = mem_pkg::vram_addr_t'(y) *
                     mem_pkg::vram_addr_t'(video_pkg::words_per_line);
  assign scan_addr = row_base + mem_pkg::vram_addr_t'(word_offset);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      h_count <= '0;
      v_count <= '0;
    end else if (clken) begin
      if (h_end) begin
        h_count <= '0;
        v_count <= v_end ? '0 : v_count + 10'd1;
      end else begin
        h_count <= h_count + 10'd1;
      end
    end
  end

  // At offset 0 the new word arrives on ram_rdata, so bit 0 comes straight from the RAM
  assign cur_bit = (px_offset == 4'd0) ? ram_rdata[0] : pixel_word[px_offset];

  always_ff @(posedge clk) begin
    if (clken && display && px_offset == 4'd0) begin
      pixel_word <= ram_rdata;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pixel       <= 1'b0;
      scan_rden   <= 1'b0;
      word_offset <= '0;
    end else if (clken) begin
      if (display) begin
        // Set bit is black, clear bit is white
        pixel <= ~cur_bit;
        case (px_offset)
          4'd0: scan_rden <= 1'b0;
          4'd8: word_offset <= word_offset + 6'd1;
          4'd13: begin
            // No fetch beyond the end of the row
            if (word_offset != 6'(video_pkg::words_per_line)) begin
              scan_rden <= 1'b1;
            end
          end
          default: ;
        endcase
      end else begin
        pixel       <= 1'b0;
        word_offset <= '0;
        scan_rden   <= pre_fetch;
      end
    end
  end

  assign red   = {4{pixel}};
  assign green = {4{pixel}};
  assign blue  = {4{pixel}};

endmodule

/* hdl/vram.sv */
module vram (
  input  logic                 clk,
  input  mem_pkg::vram_addr_t  ram_addr,
  input  logic                 ram_we,
  input  mem_pkg::vram_data_t  ram_wdata,
  output mem_pkg::vram_data_t  ram_rdata
);

  mem_pkg::vram_data_t mem [mem_pkg::vram_depth];

  // Single port, read data registered every cycle.
  // A write returns the old word on the same edge
  always_ff @(posedge clk) begin
    if (ram_we) begin
      mem[ram_addr] <= ram_wdata;
    end
    ram_rdata <= mem[ram_addr];
  end

endmodule

/* hdl/vram_arbiter.sv */
module vram_arbiter (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 scan_rden,
  input  mem_pkg::vram_addr_t  scan_addr,
  input  logic                 req_valid,
  input  logic                 req_write,
  input  mem_pkg::vram_addr_t  req_addr,
  input  mem_pkg::vram_data_t  req_wdata,
  output logic                 req_grant,
  output logic                 host_rd_done,
  output mem_pkg::vram_addr_t  ram_addr,
  output logic                 ram_we,
  output mem_pkg::vram_data_t  ram_wdata
);

  logic rd_pending;

  // Scanout always wins, host only gets cycles it leaves free
  assign req_grant = req_valid && !scan_rden;

  // Address mux, the host owns the port only in its grant cycle
  assign ram_addr  = scan_rden ? scan_addr : req_addr;
  assign ram_we    = req_grant && req_write;
  assign ram_wdata = req_wdata;

  // A granted read has its data on ram_rdata one cycle later
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_pending <= 1'b0;
    end else begin
      rd_pending <= req_grant && !req_write;
    end
  end

  assign host_rd_done = rd_pending;

endmodule

/* hdl/host_port.sv */
module host_port (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 host_wr,
  input  logic                 host_rd,
  input  mem_pkg::vram_addr_t  host_addr,
  input  mem_pkg::vram_data_t  host_wdata,
  input  logic                 req_grant,
  input  logic                 host_rd_done,
  input  mem_pkg::vram_data_t  ram_rdata,
  output logic                 host_busy,
  output logic                 host_rvalid,
  output mem_pkg::vram_data_t  host_rdata,
  output logic                 req_valid,
  output logic                 req_write,
  output mem_pkg::vram_addr_t  req_addr,
  output mem_pkg::vram_data_t  req_wdata
);

  typedef enum logic [1:0] {
    idle,
    pending,
    read_wait
  } state_t;

  state_t state;
  logic   accept;
  logic   rd_return;

  // Strobes while busy are dropped
  assign accept    = state == idle && (host_wr || host_rd);
  assign rd_return = state == read_wait && host_rd_done;

  assign host_busy = state != idle;

  // One-entry buffer, write wins if both strobes come together
  always_ff @(posedge clk) begin
    if (accept) begin
      req_write <= host_wr;
      req_addr  <= host_addr;
      req_wdata <= host_wdata;
    end
    if (rd_return) begin
      host_rdata <= ram_rdata;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state       <= idle;
      req_valid   <= 1'b0;
      host_rvalid <= 1'b0;
    end else begin
      host_rvalid <= rd_return;
      case (state)
        idle: begin
          if (accept) begin
            state <= pending;
          end
        end
        pending: begin
          // Request goes out one cycle after capture, drops on the grant
          req_valid <= !req_grant;
          if (req_grant) begin
            state <= req_write ? idle : read_wait;
          end
        end
        read_wait: begin
          if (host_rd_done) begin
            state <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

endmodule

/* hdl/video_top.sv */
module video_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 clken,
  input  logic                 host_wr,
  input  logic                 host_rd,
  input  mem_pkg::vram_addr_t  host_addr,
  input  mem_pkg::vram_data_t  host_wdata,
  output logic                 host_busy,
  output logic                 host_rvalid,
  output mem_pkg::vram_data_t  host_rdata,
  output logic                 h_sync,
  output logic                 v_sync,
  output video_pkg::colour_t   red,
  output video_pkg::colour_t   green,
  output video_pkg::colour_t   blue
);

  // Scanout side of the arbiter
  logic                scan_rden;
  mem_pkg::vram_addr_t scan_addr;

  // Host side of the arbiter
  logic                req_valid;
  logic                req_write;
  mem_pkg::vram_addr_t req_addr;
  mem_pkg::vram_data_t req_wdata;
  logic                req_grant;
  logic                host_rd_done;

  // RAM port
  mem_pkg::vram_addr_t ram_addr;
  logic                ram_we;
  mem_pkg::vram_data_t ram_wdata;
  mem_pkg::vram_data_t ram_rdata;

  vga_scanout u_vga_scanout (
    .clk       (clk),
    .rst_n     (rst_n),
    .clken     (clken),
    .ram_rdata (ram_rdata),
    .scan_rden (scan_rden),
    .scan_addr (scan_addr),
    .h_sync    (h_sync),
    .v_sync    (v_sync),
    .red       (red),
    .green     (green),
    .blue      (blue)
  );

  host_port u_host_port (
    .clk          (clk),
    .rst_n        (rst_n),
    .host_wr      (host_wr),
    .host_rd      (host_rd),
    .host_addr    (host_addr),
    .host_wdata   (host_wdata),
    .req_grant    (req_grant),
    .host_rd_done (host_rd_done),
    .ram_rdata    (ram_rdata),
    .host_busy    (host_busy),
    .host_rvalid  (host_rvalid),
    .host_rdata   (host_rdata),
    .req_valid    (req_valid),
    .req_write    (req_write),
    .req_addr     (req_addr),
    .req_wdata    (req_wdata)
  );

  vram_arbiter u_vram_arbiter (
    .clk          (clk),
    .rst_n        (rst_n),
    .scan_rden    (scan_rden),
    .scan_addr    (scan_addr),
    .req_valid    (req_valid),
    .req_write    (req_write),
    .req_addr     (req_addr),
    .req_wdata    (req_wdata),
    .req_grant    (req_grant),
    .host_rd_done (host_rd_done),
    .ram_addr     (ram_addr),
    .ram_we       (ram_we),
    .ram_wdata    (ram_wdata)
  );

  vram u_vram (
    .clk       (clk),
    .ram_addr  (ram_addr),
    .ram_we    (ram_we),
    .ram_wdata (ram_wdata),
    .ram_rdata (ram_rdata)
  );

endmodule

/* test/video_properties.sv */
module video_properties (
  input logic               clk,
  input logic               rst_n,
  input logic               host_wr,
  input logic               host_rd,
  input logic               host_busy,
  input logic               host_rvalid,
  input logic               req_grant,
  input logic               h_sync,
  input logic               v_sync,
  input video_pkg::colour_t red,
  input video_pkg::colour_t green,
  input video_pkg::colour_t blue
);

  // Host must respect busy before strobing
  a_strobe_not_busy: assert property (@(posedge clk) disable iff (!rst_n)
    (host_wr || host_rd) |-> !host_busy)
    else $error("host strobe while busy");

  // Host request drops on its grant
  a_grant_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    req_grant |=> !req_grant)
    else $error("host granted for more than one cycle");

  a_rvalid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    host_rvalid |=> !host_rvalid)
    else $error("host_rvalid longer than one cycle");

  // Blanking during sync
  a_rgb_blank: assert property (@(posedge clk) disable iff (!rst_n)
    (!h_sync || !v_sync) |-> (red == '0 && green == '0 && blue == '0))
    else $error("rgb active during sync");

endmodule

bind video_top video_properties u_video_properties (
  .clk         (clk),
  .rst_n       (rst_n),
  .host_wr     (host_wr),
  .host_rd     (host_rd),
  .host_busy   (host_busy),
  .host_rvalid (host_rvalid),
  .req_grant   (req_grant),
  .h_sync      (h_sync),
  .v_sync      (v_sync),
  .red         (red),
  .green       (green),
  .blue        (blue)
);

/* test/tb_video_top.sv */
module tb_video_top;

  logic                clk;
  logic                rst_n;
  logic                clken;
  logic                host_wr;
  logic                host_rd;
  mem_pkg::vram_addr_t host_addr;
  mem_pkg::vram_data_t host_wdata;
  logic                host_busy;
  logic                host_rvalid;
  mem_pkg::vram_data_t host_rdata;
  logic                h_sync;
  logic                v_sync;
  video_pkg::colour_t  red;
  video_pkg::colour_t  green;
  video_pkg::colour_t  blue;

  mem_pkg::vram_data_t ref_mem [mem_pkg::vram_depth];
  logic [31:0]         rng_state;
  int                  errors;

  video_top u_video_top (
    .clk         (clk),
    .rst_n       (rst_n),
    .clken       (clken),
    .host_wr     (host_wr),
    .host_rd     (host_rd),
    .host_addr   (host_addr),
    .host_wdata  (host_wdata),
    .host_busy   (host_busy),
    .host_rvalid (host_rvalid),
    .host_rdata  (host_rdata),
    .h_sync      (h_sync),
    .v_sync      (v_sync),
    .red         (red),
    .green       (green),
    .blue        (blue)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] xorshift();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // Advance one clock, then settle past the edge
  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic wait_not_busy();
    int n;
    n = 0;
    while (host_busy && n < 200) begin
      step();
      n++;
    end
    if (host_busy) begin
      $display("host_busy stayed high too long at %0t", $time);
      errors++;
    end
  endtask

  task automatic host_write(input mem_pkg::vram_addr_t addr, input mem_pkg::vram_data_t data);
    wait_not_busy();
    host_wr    = 1'b1;
    host_addr  = addr;
    host_wdata = data;
    step();
    host_wr = 1'b0;
    ref_mem[addr] = data;
    wait_not_busy();
  endtask

  task automatic host_read(input mem_pkg::vram_addr_t addr);
    int n;
    wait_not_busy();
    host_rd   = 1'b1;
    host_addr = addr;
    step();
    host_rd = 1'b0;
    n = 0;
    while (!host_rvalid && n < 200) begin
      step();
      n++;
    end
    if (!host_rvalid) begin
      $display("no read data returned for address %h at %0t", addr, $time);
      errors++;
    end else begin
      check_value("host_rdata", 32'(ref_mem[addr]), 32'(host_rdata));
    end
  endtask

  // Waits for an edge of h_sync or v_sync and returns the clocks it took
  task automatic wait_sync_edge(input bit vert, input bit rising, output int cycles);
    logic prev;
    logic cur;
    cycles = 0;
    prev = vert ? v_sync : h_sync;
    forever begin
      step();
      cycles++;
      cur = vert ? v_sync : h_sync;
      if (prev != cur && cur == rising) break;
      if (cycles > 430000) begin
        $display("sync edge never came at %0t", $time);
        errors++;
        break;
      end
      prev = cur;
    end
  endtask

  task automatic expect_reset_state();
    check_value("h_sync", 32'd1, 32'(h_sync));
    check_value("v_sync", 32'd1, 32'(v_sync));
    check_value("red", 32'd0, 32'(red));
    check_value("green", 32'd0, 32'(green));
    check_value("blue", 32'd0, 32'(blue));
    check_value("host_busy", 32'd0, 32'(host_busy));
    check_value("host_rvalid", 32'd0, 32'(host_rvalid));
  endtask

  task automatic measure_sync_timing();
    int low_len;
    int high_len;
    wait_sync_edge(1'b0, 1'b0, low_len);
    wait_sync_edge(1'b0, 1'b1, low_len);
    wait_sync_edge(1'b0, 1'b0, high_len);
    check_value("h_sync low clocks", 32'd96, 32'(low_len));
    check_value("h_sync period", 32'd800, 32'(low_len + high_len));
    wait_sync_edge(1'b1, 1'b0, low_len);
    wait_sync_edge(1'b1, 1'b1, low_len);
    wait_sync_edge(1'b1, 1'b0, high_len);
    check_value("v_sync low clocks", 32'd1600, 32'(low_len));
    check_value("v_sync period", 32'd420000, 32'(low_len + high_len));
  endtask

  task automatic write_then_read(input int count);
    mem_pkg::vram_addr_t addrs [$];
    mem_pkg::vram_addr_t a;
    for (int i = 0; i < count; i++) begin
      a = mem_pkg::vram_addr_t'(xorshift());
      // Every other access lands in the upper half of the RAM
      if (i % 2 == 0) a[13] = 1'b1;
      addrs.push_back(a);
      host_write(a, mem_pkg::vram_data_t'(xorshift()));
    end
    foreach (addrs[i]) host_read(addrs[i]);
  endtask

  task automatic access_while_scanning();
    int dummy;
    wait_sync_edge(1'b1, 1'b1, dummy);
    // Skip the blank lines down to the middle of the first visible line
    repeat ((525 - 492 + 112) * 800 + 300) step();
    write_then_read(40);
  endtask

  task automatic count_frame_pixels();
    int expected_white;
    int white;
    int cycles;
    logic prev;
    expected_white = 0;
    for (int i = 0; i < 8192; i++) begin
      host_write(mem_pkg::vram_addr_t'(i), mem_pkg::vram_data_t'(xorshift()));
      expected_white += 16 - $countones(ref_mem[i]);
    end
    wait_sync_edge(1'b1, 1'b1, cycles);
    white = 0;
    cycles = 0;
    prev = v_sync;
    forever begin
      step();
      cycles++;
      if (red != 4'd0) white++;
      if (green !== red) check_value("green", 32'(red), 32'(green));
      if (blue !== red) check_value("blue", 32'(red), 32'(blue));
      if (!prev && v_sync) break;
      if (cycles > 430000) begin
        $display("frame never ended while counting pixels at %0t", $time);
        errors++;
        break;
      end
      prev = v_sync;
    end
    check_value("white pixel count", 32'(expected_white), 32'(white));
  endtask

  initial begin
    errors     = 0;
    rng_state  = 32'd34336;
    rst_n      = 1'b0;
    clken      = 1'b1;
    host_wr    = 1'b0;
    host_rd    = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    expect_reset_state();
    measure_sync_timing();
    write_then_read(64);
    access_while_scanning();
    count_frame_pixels();
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* tb.f */
common/video_pkg.sv
common/mem_pkg.sv
vga/vga_scanout.sv
hdl/vram.sv
hdl/vram_arbiter.sv
hdl/host_port.sv
hdl/video_top.sv
test/video_properties.sv
test/tb_video_top.sv

/* run_sim.sh */
#!/bin/bash
# Build and run the testbench with Verilator, then check the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_video_top -o sim_tb \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || echo "build or run returned an error"

grep -q "Simulation completed successfully" sim.log \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }
